// File: build.f
+incdir+common
common/mcl_bridge_pkg.sv
source/word_fifo.sv
source/word_upsizer.sv
source/word_downsizer.sv
host/axil_host_regs.sv
source/mcl_bridge_top.sv
verification/mcl_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the mcl bridge testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f build.f --top-module mcl_bridge_tb \
  --Mdir obj_dir -o mcl_bridge_sim
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/mcl_bridge_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
  echo "no verdict found in $LOG"
  exit 1
fi
exit 0

// File: verification/mcl_bridge_tb.sv
// testbench for the mcl bridge top level
// step table, lfsr data source, compare tasks and a cycle watchdog

`include "mcl_bridge_defines.svh"

module mcl_bridge_tb
  import mcl_bridge_pkg::*;
();

  localparam int reset_cycles_lp    = 5;
  localparam int cycles_per_step_lp = 40;

  typedef enum logic [2:0] {
    OP_WRITE, OP_READ, OP_SEND, OP_EXPECT, OP_STALL, OP_SETTLE
  } op_e;

  typedef struct packed {
    op_e        op;
    host_addr_t addr;
    host_word_t data;          // read data, or mcl_r_i level for a stall
    axil_resp_t resp;
    int         reps;          // repeat count, cycles for a settle
    rcv_count_t credits;       // expected after a settle
    logic       ready;         // expected mcl_r_o after a settle
  } step_s;

  logic        clk = 1'b0;
  logic        reset;
  axil_req_s   axil_req;
  axil_rsp_s   axil_rsp;
  logic        chan_in_v, chan_in_ready, chan_out_v, chan_out_ready;
  mcl_word_t   chan_in_data, chan_out_data;
  rcv_count_t  rcv_vacancy;

  step_s       steps[$];
  host_word_t  tx_words[$];    // accepted tx writes, oldest first
  host_word_t  rx_words[$];    // sent on the channel, not yet read
  mcl_word_t   chan_got[$];
  logic [31:0] lfsr_state = 32'd85;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  always #4 clk = ~clk;

  mcl_bridge_top i_mcl_bridge_top (
    .clk_i(clk), .reset_i(reset)
    ,.axil_req_i(axil_req), .axil_rsp_o(axil_rsp)
    ,.mcl_v_i(chan_in_v), .mcl_data_i(chan_in_data), .mcl_r_o(chan_in_ready)
    ,.mcl_v_o(chan_out_v), .mcl_data_o(chan_out_data), .mcl_r_i(chan_out_ready)
    ,.rcv_vacancy_o(rcv_vacancy)
  );

  // helpers ---------------------
  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("the run did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  // galois lfsr, x^32+x^22+x^2+x+1
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic host_word_t rand_word();
    host_word_t w;
    for (int i = 0; i < `HOST_WIDTH; i++) w[i] = lfsr_bit();
    return w;
  endfunction

  task automatic tick();
    if (chan_out_v && chan_out_ready) begin
      chan_got.push_back(chan_out_data);     // moves at the coming rising edge
    end
    @(negedge clk);
  endtask

  task automatic check_word(string name, host_word_t got, host_word_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_mcl(string name, mcl_word_t got, mcl_word_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_resp(string name, axil_resp_t got, axil_resp_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(string name, rcv_count_t got, rcv_count_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // bus and channel steps -------
  task automatic host_write(host_addr_t addr, axil_resp_t exp_resp);
    host_word_t wdata;
    wdata = rand_word();
    axil_req.awaddr  = addr;
    axil_req.wdata   = wdata;
    axil_req.wstrb   = '1;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    #1;                                      // inside the accept cycle
    check_flag("awready", axil_rsp.awready, 1'b1);
    check_flag("wready", axil_rsp.wready, 1'b1);
    do tick(); while (!axil_rsp.bvalid);
    check_flag("awready", axil_rsp.awready, 1'b0);   // held off while bvalid
    check_flag("wready", axil_rsp.wready, 1'b0);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    check_resp("bresp", axil_rsp.bresp, exp_resp);
    if (addr == `REG_TX_DATA && exp_resp == `RESP_OKAY) tx_words.push_back(wdata);
    axil_req.bready = 1'b1;
    tick();
    axil_req.bready = 1'b0;
  endtask

  task automatic host_read(host_addr_t addr, host_word_t exp_data, axil_resp_t exp_resp);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    #1;                                      // inside the accept cycle
    check_flag("arready", axil_rsp.arready, 1'b1);
    do tick(); while (!axil_rsp.rvalid);
    check_flag("arready", axil_rsp.arready, 1'b0);   // held off while rvalid
    axil_req.arvalid = 1'b0;
    check_resp("rresp", axil_rsp.rresp, exp_resp);
    check_word("rdata", axil_rsp.rdata, exp_data);
    axil_req.rready = 1'b1;
    tick();
    axil_req.rready = 1'b0;
  endtask

  task automatic chan_send();
    host_word_t part;
    for (int k = 0; k < `WORDS_PER_MCL; k++) begin
      part = rand_word();
      chan_in_data[k*`HOST_WIDTH +: `HOST_WIDTH] = part;   // word k in slice k
      rx_words.push_back(part);
    end
    chan_in_v = 1'b1;
    while (!chan_in_ready) tick();
    tick();
    chan_in_v = 1'b0;
  endtask

  task automatic chan_expect();
    mcl_word_t exp, got;
    if (tx_words.size() < `WORDS_PER_MCL) begin
      $display("fewer than four written host words remain for a channel word");
      abort_run();
    end
    for (int k = 0; k < `WORDS_PER_MCL; k++) begin
      exp[k*`HOST_WIDTH +: `HOST_WIDTH] = tx_words.pop_front();
    end
    while (chan_got.size() == 0) tick();
    got = chan_got.pop_front();
    check_mcl("mcl_data_o", got, exp);
  endtask

  task automatic add_step(op_e op, host_addr_t addr, host_word_t data, axil_resp_t resp,
                          int reps, rcv_count_t credits, logic ready);
    steps.push_back('{op, addr, data, resp, reps, credits, ready});
  endtask

  // step table ------------------
  task automatic build_table();
    add_step(OP_SETTLE, 4'h0, 32'd0, `RESP_OKAY, 1, 3'd4, 1'b1);        // after reset
    add_step(OP_READ, `REG_TX_VACANCY, 32'd16, `RESP_OKAY, 1, 3'd0, 1'b0);
    add_step(OP_READ, `REG_RX_OCCUPANCY, 32'd0, `RESP_OKAY, 1, 3'd0, 1'b0);
    add_step(OP_WRITE, `REG_TX_DATA, 32'd0, `RESP_OKAY, 4, 3'd0, 1'b0);  // packing
    add_step(OP_EXPECT, 4'h0, 32'd0, `RESP_OKAY, 1, 3'd0, 1'b0);
    add_step(OP_STALL, 4'h0, 32'd0, `RESP_OKAY, 1, 3'd0, 1'b0);          // back-pressure
    add_step(OP_WRITE, `REG_TX_DATA, 32'd0, `RESP_OKAY, 20, 3'd0, 1'b0);
    add_step(OP_WRITE, `REG_TX_DATA, 32'd0, `RESP_SLVERR, 1, 3'd0, 1'b0);
    add_step(OP_READ, `REG_TX_VACANCY, 32'd0, `RESP_OKAY, 1, 3'd0, 1'b0);
    add_step(OP_STALL, 4'h0, 32'd1, `RESP_OKAY, 1, 3'd0, 1'b0);
    add_step(OP_EXPECT, 4'h0, 32'd0, `RESP_OKAY, 5, 3'd0, 1'b0);
    add_step(OP_READ, `REG_TX_VACANCY, 32'd16, `RESP_OKAY, 1, 3'd0, 1'b0);
    add_step(OP_SEND, 4'h0, 32'd0, `RESP_OKAY, 2, 3'd0, 1'b0);           // splitting
    add_step(OP_SETTLE, 4'h0, 32'd0, `RESP_OKAY, 30, 3'd4, 1'b1);
    add_step(OP_READ, `REG_RX_OCCUPANCY, 32'd8, `RESP_OKAY, 1, 3'd0, 1'b0);
    add_step(OP_READ, `REG_RX_DATA, 32'd0, `RESP_OKAY, 8, 3'd0, 1'b0);
    add_step(OP_READ, `REG_RX_DATA, 32'd0, `RESP_SLVERR, 1, 3'd0, 1'b0);
    add_step(OP_SEND, 4'h0, 32'd0, `RESP_OKAY, 5, 3'd0, 1'b0);           // credits
    add_step(OP_SETTLE, 4'h0, 32'd0, `RESP_OKAY, 40, 3'd4, 1'b1);
    add_step(OP_SEND, 4'h0, 32'd0, `RESP_OKAY, 2, 3'd0, 1'b0);
    add_step(OP_SETTLE, 4'h0, 32'd0, `RESP_OKAY, 30, 3'd2, 1'b1);
    add_step(OP_SEND, 4'h0, 32'd0, `RESP_OKAY, 2, 3'd0, 1'b0);
    add_step(OP_SETTLE, 4'h0, 32'd0, `RESP_OKAY, 30, 3'd0, 1'b0);
    add_step(OP_READ, `REG_RX_OCCUPANCY, 32'd16, `RESP_OKAY, 1, 3'd0, 1'b0);
    add_step(OP_READ, `REG_RX_DATA, 32'd0, `RESP_OKAY, 4, 3'd0, 1'b0);
    add_step(OP_SETTLE, 4'h0, 32'd0, `RESP_OKAY, 30, 3'd1, 1'b1);
    add_step(OP_READ, `REG_RX_DATA, 32'd0, `RESP_OKAY, 32, 3'd0, 1'b0);
    add_step(OP_SETTLE, 4'h0, 32'd0, `RESP_OKAY, 30, 3'd4, 1'b1);
    add_step(OP_READ, `REG_RX_OCCUPANCY, 32'd0, `RESP_OKAY, 1, 3'd0, 1'b0);
    add_step(OP_WRITE, `REG_TX_VACANCY, 32'd0, `RESP_SLVERR, 1, 3'd0, 1'b0);  // errors
    add_step(OP_WRITE, `REG_RX_OCCUPANCY, 32'd0, `RESP_SLVERR, 1, 3'd0, 1'b0);
    add_step(OP_WRITE, `REG_RX_DATA, 32'd0, `RESP_SLVERR, 1, 3'd0, 1'b0);
    add_step(OP_READ, 4'h2, 32'd0, `RESP_SLVERR, 1, 3'd0, 1'b0);
    add_step(OP_READ, `REG_TX_VACANCY, 32'd16, `RESP_OKAY, 1, 3'd0, 1'b0);
  endtask

  // main sequence ---------------
  initial begin
    step_s      s;
    host_word_t exp_data;
    reset          = 1'b1;
    axil_req       = '0;
    chan_in_v      = 1'b0;
    chan_in_data   = '0;
    chan_out_ready = 1'b1;
    build_table();
    cycle_limit = steps.size() * cycles_per_step_lp + reset_cycles_lp;
    repeat (reset_cycles_lp) tick();
    reset = 1'b0;
    check_flag("mcl_v_o", chan_out_v, 1'b0);
    check_flag("awready", axil_rsp.awready, 1'b0);
    check_flag("wready", axil_rsp.wready, 1'b0);
    check_flag("arready", axil_rsp.arready, 1'b0);
    check_flag("bvalid", axil_rsp.bvalid, 1'b0);
    check_flag("rvalid", axil_rsp.rvalid, 1'b0);
    foreach (steps[i]) begin
      s = steps[i];
      case (s.op)
        OP_WRITE:  repeat (s.reps) host_write(s.addr, s.resp);
        OP_READ: begin
          repeat (s.reps) begin
            exp_data = s.data;
            if (s.addr == `REG_RX_DATA && s.resp == `RESP_OKAY) begin
              if (rx_words.size() == 0) begin
                $display("a data read was expected to succeed with no word in flight");
                abort_run();
              end
              exp_data = rx_words.pop_front();
            end
            host_read(s.addr, exp_data, s.resp);
          end
        end
        OP_SEND:   repeat (s.reps) chan_send();
        OP_EXPECT: repeat (s.reps) chan_expect();
        OP_STALL:  chan_out_ready = s.data[0];
        OP_SETTLE: begin
          repeat (s.reps) tick();
          check_count("rcv_vacancy_o", rcv_vacancy, s.credits);
          check_flag("mcl_r_o", chan_in_ready, s.ready);
        end
        default: begin
          $display("the step table holds an unknown step code");
          abort_run();
        end
      endcase
    end
    if (chan_got.size() != 0) begin
      $display("a channel word left the bridge with no writes behind it");
      abort_run();
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

// File: source/mcl_bridge_top.sv
// top level of the axi-lite to mcl bridge
// host registers, tx fifo and upsizer, rx buffer, downsizer and rx fifo

`include "mcl_bridge_defines.svh"

module mcl_bridge_top
  import mcl_bridge_pkg::*;
(
  input  logic       clk_i
  ,input  logic       reset_i

  ,input  axil_req_s  axil_req_i
  ,output axil_rsp_s  axil_rsp_o

  ,input  logic       mcl_v_i
  ,input  mcl_word_t  mcl_data_i
  ,output logic       mcl_r_o

  ,output logic       mcl_v_o
  ,output mcl_word_t  mcl_data_o
  ,input  logic       mcl_r_i

  ,output rcv_count_t rcv_vacancy_o
);

  localparam int tx_vac_w_lp = $clog2(`TX_FIFO_DEPTH+1);
  localparam int rx_vac_w_lp = $clog2(`RX_FIFO_DEPTH+1);

  logic                   tx_v, tx_r, txf_v, up_r;
  host_word_t             tx_data, txf_data;
  logic [tx_vac_w_lp-1:0] tx_vac;
  logic                   rcv_v, rcv_yumi;
  mcl_word_t              rcv_data;
  logic                   dn_v, dn_r, rxf_v, rxf_yumi;
  host_word_t             dn_data, rxf_data;
  logic [rx_vac_w_lp-1:0] rx_vac, rx_occ;
  host_word_t             tx_vacancy, rx_occupancy;

  // status, zero extended to the host width
  assign rx_occ       = rx_vac_w_lp'(`RX_FIFO_DEPTH) - rx_vac;
  assign tx_vacancy   = host_word_t'(tx_vac);
  assign rx_occupancy = host_word_t'(rx_occ);

  axil_host_regs i_axil_host_regs (
    .clk_i(clk_i), .reset_i(reset_i)
    ,.axil_req_i(axil_req_i), .axil_rsp_o(axil_rsp_o)
    ,.rx_v_i(rxf_v), .rx_data_i(rxf_data), .rx_yumi_o(rxf_yumi)
    ,.tx_v_o(tx_v), .tx_data_o(tx_data), .tx_r_i(tx_r)
    ,.tx_vacancy_i(tx_vacancy), .rx_occupancy_i(rx_occupancy)
  );

  // transmit path ----------------
  word_fifo #(.width_p(`HOST_WIDTH), .depth_p(`TX_FIFO_DEPTH)) i_tx_fifo (
    .clk_i(clk_i), .reset_i(reset_i)
    ,.v_i(tx_v), .data_i(tx_data), .ready_o(tx_r)
    ,.v_o(txf_v), .data_o(txf_data), .yumi_i(txf_v & up_r)
    ,.vacancy_o(tx_vac)
  );

  word_upsizer i_word_upsizer (
    .clk_i(clk_i), .reset_i(reset_i)
    ,.v_i(txf_v), .data_i(txf_data), .ready_o(up_r)
    ,.mcl_v_o(mcl_v_o), .mcl_data_o(mcl_data_o), .mcl_r_i(mcl_r_i)
  );

  // receive path -----------------
  word_fifo #(.width_p(`MCL_WIDTH), .depth_p(`RCV_DEPTH)) i_rcv_fifo (
    .clk_i(clk_i), .reset_i(reset_i)
    ,.v_i(mcl_v_i), .data_i(mcl_data_i), .ready_o(mcl_r_o)
    ,.v_o(rcv_v), .data_o(rcv_data), .yumi_i(rcv_yumi)
    ,.vacancy_o(rcv_vacancy_o)                 // credits back to the sender
  );

  word_downsizer i_word_downsizer (
    .clk_i(clk_i), .reset_i(reset_i)
    ,.v_i(rcv_v), .data_i(rcv_data), .yumi_o(rcv_yumi)
    ,.v_o(dn_v), .data_o(dn_data), .r_i(dn_r)
  );

  word_fifo #(.width_p(`HOST_WIDTH), .depth_p(`RX_FIFO_DEPTH)) i_rx_fifo (
    .clk_i(clk_i), .reset_i(reset_i)
    ,.v_i(dn_v), .data_i(dn_data), .ready_o(dn_r)
    ,.v_o(rxf_v), .data_o(rxf_data), .yumi_i(rxf_yumi)
    ,.vacancy_o(rx_vac)
  );

endmodule

// File: host/axil_host_regs.sv
// axi-lite slave for the mcl bridge
// register decode, tx data push, rx data pop, status reads

`include "mcl_bridge_defines.svh"

module axil_host_regs
  import mcl_bridge_pkg::*;
(
  input  logic       clk_i
  ,input  logic       reset_i

  ,input  axil_req_s  axil_req_i
  ,output axil_rsp_s  axil_rsp_o

  // receive fifo side
  ,input  logic       rx_v_i
  ,input  host_word_t rx_data_i
  ,output logic       rx_yumi_o

  // transmit fifo side
  ,output logic       tx_v_o
  ,output host_word_t tx_data_o
  ,input  logic       tx_r_i

  ,input  host_word_t tx_vacancy_i
  ,input  host_word_t rx_occupancy_i
);

  logic       wr_fire, rd_fire;
  logic       tx_hit;
  logic       bvalid_r, rvalid_r;
  axil_resp_t bresp_r, rresp_r;
  host_word_t rdata_r;
  axil_resp_t rd_resp_n;
  host_word_t rd_data_n;

  // write channel ----------------
  assign wr_fire = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_r;
  assign tx_hit  = (axil_req_i.awaddr == `REG_TX_DATA);

  assign tx_v_o    = wr_fire & tx_hit;          // dropped by the fifo when full
  assign tx_data_o = axil_req_i.wdata;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bvalid_r <= 1'b0;
    end else if (wr_fire) begin
      bvalid_r <= 1'b1;
    end else if (axil_req_i.bready) begin
      bvalid_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      bresp_r <= (tx_hit & tx_r_i) ? `RESP_OKAY : `RESP_SLVERR;
    end
  end

  // read channel -----------------
  assign rd_fire   = axil_req_i.arvalid & ~rvalid_r;
  assign rx_yumi_o = rd_fire & rx_v_i & (axil_req_i.araddr == `REG_RX_DATA);

  always_comb begin
    rd_resp_n = `RESP_OKAY;
    rd_data_n = '0;
    case (axil_req_i.araddr)
      `REG_RX_DATA: begin
        if (rx_v_i) begin
          rd_data_n = rx_data_i;
        end else begin
          rd_resp_n = `RESP_SLVERR;       // nothing to pop
        end
      end
      `REG_TX_VACANCY:   rd_data_n = tx_vacancy_i;
      `REG_RX_OCCUPANCY: rd_data_n = rx_occupancy_i;
      default:           rd_resp_n = `RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_r <= 1'b0;
    end else if (rd_fire) begin
      rvalid_r <= 1'b1;
    end else if (axil_req_i.rready) begin
      rvalid_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      rdata_r <= rd_data_n;
      rresp_r <= rd_resp_n;
    end
  end

  // response bus
  assign axil_rsp_o.awready = wr_fire;          // aw and w taken together
  assign axil_rsp_o.wready  = wr_fire;
  assign axil_rsp_o.bresp   = bresp_r;
  assign axil_rsp_o.bvalid  = bvalid_r;
  assign axil_rsp_o.arready = rd_fire;
  assign axil_rsp_o.rdata   = rdata_r;
  assign axil_rsp_o.rresp   = rresp_r;
  assign axil_rsp_o.rvalid  = rvalid_r;

endmodule

// File: source/word_downsizer.sv
// channel word to host word splitter
// emits the low host word first

`include "mcl_bridge_defines.svh"

module word_downsizer
  import mcl_bridge_pkg::*;
(
  input  logic       clk_i
  ,input  logic       reset_i

  ,input  logic       v_i
  ,input  mcl_word_t  data_i
  ,output logic       yumi_o

  ,output logic       v_o
  ,output host_word_t data_o
  ,input  logic       r_i
);

  localparam int idx_w_lp = $clog2(`WORDS_PER_MCL);

  mcl_word_t           hold_r;
  logic [idx_w_lp-1:0] idx_r;
  logic                full_r;
  logic                emit;

  assign yumi_o = v_i & ~full_r;               // load only when empty
  assign emit   = full_r & r_i;
  assign v_o    = full_r;
  assign data_o = hold_r[idx_r*`HOST_WIDTH +: `HOST_WIDTH];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      idx_r  <= '0;
      full_r <= 1'b0;
    end else if (yumi_o) begin
      idx_r  <= '0;
      full_r <= 1'b1;
    end else if (emit) begin
      idx_r <= idx_r + 1'b1;
      if (idx_r == idx_w_lp'(`WORDS_PER_MCL-1)) begin
        full_r <= 1'b0;                        // last slice taken
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (yumi_o) begin
      hold_r <= data_i;
    end
  end

endmodule

// File: source/word_upsizer.sv
// host word to channel word packer
// four host words, least significant first, per channel word

`include "mcl_bridge_defines.svh"

module word_upsizer
  import mcl_bridge_pkg::*;
(
  input  logic       clk_i
  ,input  logic       reset_i

  ,input  logic       v_i
  ,input  host_word_t data_i
  ,output logic       ready_o

  ,output logic       mcl_v_o
  ,output mcl_word_t  mcl_data_o
  ,input  logic       mcl_r_i
);

  localparam int cnt_w_lp = $clog2(`WORDS_PER_MCL);

  logic [cnt_w_lp-1:0] cnt_r;
  logic                full_r;
  logic                take;
  mcl_word_t           data_r;

  assign ready_o    = ~full_r;                 // closed while holding a word
  assign take       = v_i & ~full_r;
  assign mcl_v_o    = full_r;
  assign mcl_data_o = data_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_r  <= '0;
      full_r <= 1'b0;
    end else begin
      if (take) begin
        cnt_r <= cnt_r + 1'b1;                 // wraps after the last word
      end
      if (take && cnt_r == cnt_w_lp'(`WORDS_PER_MCL-1)) begin
        full_r <= 1'b1;
      end else if (full_r && mcl_r_i) begin
        full_r <= 1'b0;
      end
    end
  end

  // shift in from the top, first word ends up in the low slice
  always_ff @(posedge clk_i) begin
    if (take) begin
      data_r <= {data_i, data_r[`MCL_WIDTH-1:`HOST_WIDTH]};
    end
  end

endmodule

// File: source/word_fifo.sv
// first-word-fall-through fifo with registered vacancy count
// parameterized in width and depth

module word_fifo #(
  parameter int width_p = 32
  ,parameter int depth_p = 16
  ,localparam int ptr_w_lp = (depth_p > 1) ? $clog2(depth_p) : 1
  ,localparam int vac_w_lp = $clog2(depth_p+1)
)(
  input  logic                clk_i
  ,input  logic                reset_i

  ,input  logic                v_i
  ,input  logic [width_p-1:0]  data_i
  ,output logic                ready_o

  ,output logic                v_o
  ,output logic [width_p-1:0]  data_o
  ,input  logic                yumi_i

  ,output logic [vac_w_lp-1:0] vacancy_o
);

  logic [width_p-1:0]  mem_r [depth_p];
  logic [ptr_w_lp-1:0] wptr_r, rptr_r;
  logic [vac_w_lp-1:0] vac_r;
  logic                push, pop;

  assign ready_o   = (vac_r != '0);                  // low only when full
  assign v_o       = (vac_r != vac_w_lp'(depth_p));
  assign data_o    = mem_r[rptr_r];
  assign vacancy_o = vac_r;

  assign push = v_i & ready_o;
  assign pop  = yumi_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r <= '0;
      rptr_r <= '0;
      vac_r  <= vac_w_lp'(depth_p);
    end else begin
      if (push) begin
        wptr_r <= (wptr_r == ptr_w_lp'(depth_p-1)) ? '0 : wptr_r + 1'b1;
      end
      if (pop) begin
        rptr_r <= (rptr_r == ptr_w_lp'(depth_p-1)) ? '0 : rptr_r + 1'b1;
      end
      case ({push, pop})
        2'b10:   vac_r <= vac_r - 1'b1;
        2'b01:   vac_r <= vac_r + 1'b1;
        default: vac_r <= vac_r;        // both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wptr_r] <= data_i;
    end
  end

endmodule

// File: common/mcl_bridge_pkg.sv
// word typedefs for host and channel data
// axi-lite request and response structs

`include "mcl_bridge_defines.svh"

package mcl_bridge_pkg;

  typedef logic [`HOST_WIDTH-1:0]          host_word_t;
  typedef logic [`HOST_ADDR_WIDTH-1:0]     host_addr_t;
  typedef logic [`MCL_WIDTH-1:0]           mcl_word_t;
  typedef logic [1:0]                      axil_resp_t;
  typedef logic [$clog2(`RCV_DEPTH+1)-1:0] rcv_count_t;   // 0 .. RCV_DEPTH

  // host -> bridge
  typedef struct packed {
    host_addr_t              awaddr;
    logic                    awvalid;
    host_word_t              wdata;
    logic [`HOST_WIDTH/8-1:0] wstrb;   // not decoded
    logic                    wvalid;
    logic                    bready;
    host_addr_t              araddr;
    logic                    arvalid;
    logic                    rready;
  } axil_req_s;

  // bridge -> host
  typedef struct packed {
    logic       awready;
    logic       wready;
    axil_resp_t bresp;
    logic       bvalid;
    logic       arready;
    host_word_t rdata;
    axil_resp_t rresp;
    logic       rvalid;
  } axil_rsp_s;

endpackage

// File: common/mcl_bridge_defines.svh
// width, depth and register map macros for the mcl bridge
// axi-lite response codes

`ifndef MCL_BRIDGE_DEFINES_SVH
`define MCL_BRIDGE_DEFINES_SVH

// widths ------------------------
`define MCL_WIDTH        128
`define HOST_WIDTH       32
`define HOST_ADDR_WIDTH  4
`define WORDS_PER_MCL    4

// depths ------------------------
`define TX_FIFO_DEPTH    16       // host words
`define RX_FIFO_DEPTH    16       // host words
`define RCV_DEPTH        4        // channel words, credit maximum

// register offsets --------------
`define REG_TX_DATA      4'h0
`define REG_TX_VACANCY   4'h4
`define REG_RX_DATA      4'h8
`define REG_RX_OCCUPANCY 4'hC

`define RESP_OKAY        2'b00
`define RESP_SLVERR      2'b10

`endif
